/* src/psx_load_pkg.sv */
//========================================
// psx loader shared definitions
// widths, download index codes and the
// download kind used by decoder and writer
//========================================
package psx_load_pkg;

	//========================================
	// widths
	//========================================

	// byte address into main or cd memory
	typedef logic [26:0] ram_addr_t;
	// one 32-bit memory write word
	typedef logic [31:0] ram_word_t;
	// one host transfer word
	typedef logic [15:0] host_half_t;
	// host download index
	typedef logic [7:0]  dl_index_t;
	// cd image size in bytes
	typedef logic [29:0] cd_size_t;
	// mounted image size as reported by the host
	typedef logic [63:0] img_size_t;

	//========================================
	// download index codes
	//========================================

	// bios and exe match on all 8 bits
	localparam dl_index_t IDX_BIOS = 8'd0;
	localparam dl_index_t IDX_EXE  = 8'd1;
	// cd matches on the low 6 bits only
	localparam dl_index_t IDX_CD   = 8'd2;

	// active download kind, also the decoder state
	typedef enum logic [1:0] {
		DL_NONE = 2'd0,
		DL_BIOS = 2'd1,
		DL_EXE  = 2'd2,
		DL_CD   = 2'd3
	} dl_kind_e;

endpackage

/* src/download_decoder.sv */
//========================================
// download decoder
// classifies the host download, tracks
// cd, exe start and loaded status
//========================================
`timescale 1ns/10ps

module download_decoder (
	input  logic                    clk_1x,
	input  logic                    reset,
	input  logic                    reset_in,
	input  logic                    ioctl_download,
	input  psx_load_pkg::dl_index_t ioctl_index,
	input  psx_load_pkg::ram_addr_t ioctl_addr,
	input  logic                    img_mounted,
	input  psx_load_pkg::img_size_t img_size,
	output psx_load_pkg::dl_kind_e  kind,
	output logic                    load_exe,
	output psx_load_pkg::cd_size_t  cd_size,
	output logic                    has_cd,
	output logic                    cd_from_card,
	output logic                    content_loaded,
	output logic                    core_reset,
	output logic                    led_user
);
	import psx_load_pkg::*;

	// decoded kind before the register
	dl_kind_e kind_next;
	// kind one cycle back, for end of download
	dl_kind_e kind_prev;
	logic     exe_end;
	logic     cd_end;

	//========================================
	// index decode
	//========================================

	always_comb begin
		kind_next = DL_NONE;
		if (ioctl_download) begin
			if (ioctl_index == IDX_BIOS) begin
				kind_next = DL_BIOS;
			end else if (ioctl_index == IDX_EXE) begin
				kind_next = DL_EXE;
			end else if (ioctl_index[5:0] == IDX_CD[5:0]) begin
				// upper index bits select the cd slot, ignored here
				kind_next = DL_CD;
			end
		end
	end

	// falling edge of a registered download kind
	assign exe_end = (kind_prev == DL_EXE) && (kind != DL_EXE);
	assign cd_end  = (kind_prev == DL_CD) && (kind != DL_CD);

	//========================================
	// status registers
	//========================================

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			kind           <= DL_NONE;
			kind_prev      <= DL_NONE;
			load_exe       <= 1'b0;
			has_cd         <= 1'b0;
			cd_from_card   <= 1'b0;
			content_loaded <= 1'b0;
		end else begin
			kind      <= kind_next;
			kind_prev <= kind;
			// one cycle start pulse for the system
			load_exe  <= exe_end;
			// cd from the host transfer
			if (cd_end) begin
				has_cd       <= 1'b1;
				cd_from_card <= 1'b0;
			end
			// mount wins over a finishing download
			if (img_mounted) begin
				has_cd       <= 1'b1;
				cd_from_card <= 1'b1;
			end
			// sticky, only reset clears it
			if (kind == DL_EXE || kind == DL_CD || img_mounted) begin
				content_loaded <= 1'b1;
			end
		end
	end

	// cd size, same priority as the flags above
	always_ff @(posedge clk_1x) begin
		if (img_mounted) begin
			cd_size <= img_size[29:0];
		end else if (cd_end) begin
			// last byte address of the transfer
			cd_size <= cd_size_t'(ioctl_addr);
		end
	end

	//========================================
	// core reset and led
	//========================================

	// system held in reset while exe or cd streams in
	assign core_reset = reset_in | (kind == DL_EXE) | (kind == DL_CD) | img_mounted;
	assign led_user   = (kind != DL_NONE);

endmodule

/* src/download_writer.sv */
//========================================
// download writer
// packs host halfwords into memory words,
// offsets and routes them, holds the host
//========================================
`timescale 1ns/10ps

module download_writer #(
	parameter int unsigned bios_base = 2097152,
	parameter int unsigned exe_base  = 4194304
) (
	input  logic                     clk_1x,
	input  logic                     reset,
	input  psx_load_pkg::dl_kind_e   kind,
	input  logic                     ioctl_wr,
	input  psx_load_pkg::ram_addr_t  ioctl_addr,
	input  psx_load_pkg::host_half_t ioctl_dout,
	output logic                     ioctl_wait,
	output psx_load_pkg::ram_addr_t  main_addr,
	output psx_load_pkg::ram_word_t  main_data,
	output logic                     main_req,
	input  logic                     main_ack,
	output psx_load_pkg::ram_addr_t  cd_addr,
	output psx_load_pkg::ram_word_t  cd_data,
	output logic                     cd_req,
	input  logic                     cd_ack
);
	import psx_load_pkg::*;

	// collect two halves, then wait for the memory
	typedef enum logic {
		PK_COLLECT = 1'b0,
		PK_WAIT    = 1'b1
	} pk_state_e;

	// bases cut down to the memory address width
	localparam ram_addr_t bios_off = ram_addr_t'(bios_base);
	localparam ram_addr_t exe_off  = ram_addr_t'(exe_base);

	pk_state_e state;
	ram_addr_t base_off;
	ram_addr_t word_addr;
	ram_word_t word_data;
	logic      route_cd;
	logic      active;
	logic      take_wr;
	logic      routed_ack;

	//========================================
	// offset and handshake decode
	//========================================

	always_comb begin
		case (kind)
			DL_BIOS: base_off = bios_off;
			DL_EXE:  base_off = exe_off;
			// cd goes to its own memory at zero
			default: base_off = '0;
		endcase
	end

	assign active  = (kind != DL_NONE);
	// host only writes while not stalled
	assign take_wr = active && ioctl_wr && (state == PK_COLLECT);
	// ack on the other channel is not ours
	assign routed_ack = route_cd ? cd_ack : main_ack;

	//========================================
	// packing fsm
	//========================================

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			state    <= PK_COLLECT;
			main_req <= 1'b0;
			cd_req   <= 1'b0;
		end else begin
			// requests are single cycle
			main_req <= 1'b0;
			cd_req   <= 1'b0;
			if (!active) begin
				// download gone, drop any pending word
				state <= PK_COLLECT;
			end else begin
				case (state)
					PK_COLLECT: begin
						// high half completes the word
						if (take_wr && ioctl_addr[1]) begin
							state    <= PK_WAIT;
							main_req <= (kind != DL_CD);
							cd_req   <= (kind == DL_CD);
						end
					end
					PK_WAIT: begin
						if (routed_ack) begin
							state <= PK_COLLECT;
						end
					end
					default: state <= PK_COLLECT;
				endcase
			end
		end
	end

	// word assembly
	always_ff @(posedge clk_1x) begin
		if (take_wr) begin
			if (!ioctl_addr[1]) begin
				// low half carries the word address
				word_data[15:0] <= ioctl_dout;
				word_addr       <= ioctl_addr + base_off;
			end else begin
				word_data[31:16] <= ioctl_dout;
				route_cd         <= (kind == DL_CD);
			end
		end
	end

	// host stalls for exactly one word in flight
	assign ioctl_wait = (state == PK_WAIT);

	// both channels see the same word, req picks one
	assign main_addr = word_addr;
	assign main_data = word_data;
	assign cd_addr   = word_addr;
	assign cd_data   = word_data;

endmodule

/* src/psx_loader_top.sv */
//========================================
// psx loader top level
// host download front end, decoder plus
// memory writer on plain ports
//========================================
`timescale 1ns/10ps

module psx_loader_top #(
	parameter int unsigned bios_base = 2097152,
	parameter int unsigned exe_base  = 4194304
) (
	input  logic                     clk_1x,
	input  logic                     reset,
	// host download side
	input  logic                     ioctl_download,
	input  psx_load_pkg::dl_index_t  ioctl_index,
	input  psx_load_pkg::ram_addr_t  ioctl_addr,
	input  psx_load_pkg::host_half_t ioctl_dout,
	input  logic                     ioctl_wr,
	output logic                     ioctl_wait,
	input  logic                     img_mounted,
	input  psx_load_pkg::img_size_t  img_size,
	// main memory write channel
	output psx_load_pkg::ram_addr_t  main_addr,
	output psx_load_pkg::ram_word_t  main_data,
	output logic                     main_req,
	input  logic                     main_ack,
	// cd memory write channel
	output psx_load_pkg::ram_addr_t  cd_addr,
	output psx_load_pkg::ram_word_t  cd_data,
	output logic                     cd_req,
	input  logic                     cd_ack,
	// system side status
	output logic                     load_exe,
	output psx_load_pkg::cd_size_t   cd_size,
	output logic                     has_cd,
	output logic                     cd_from_card,
	output logic                     content_loaded,
	output logic                     core_reset,
	output logic                     led_user
);
	import psx_load_pkg::*;

	// registered download kind, decoder to writer
	dl_kind_e kind;

	download_decoder i_download_decoder (
		.clk_1x         (clk_1x),
		.reset          (reset),
		.reset_in       (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.img_mounted    (img_mounted),
		.img_size       (img_size),
		.kind           (kind),
		.load_exe       (load_exe),
		.cd_size        (cd_size),
		.has_cd         (has_cd),
		.cd_from_card   (cd_from_card),
		.content_loaded (content_loaded),
		.core_reset     (core_reset),
		.led_user       (led_user)
	);

	download_writer #(
		.bios_base (bios_base),
		.exe_base  (exe_base)
	) i_download_writer (
		.clk_1x     (clk_1x),
		.reset      (reset),
		.kind       (kind),
		.ioctl_wr   (ioctl_wr),
		.ioctl_addr (ioctl_addr),
		.ioctl_dout (ioctl_dout),
		.ioctl_wait (ioctl_wait),
		.main_addr  (main_addr),
		.main_data  (main_data),
		.main_req   (main_req),
		.main_ack   (main_ack),
		.cd_addr    (cd_addr),
		.cd_data    (cd_data),
		.cd_req     (cd_req),
		.cd_ack     (cd_ack)
	);

endmodule

/* test/loader_tasks.svh */
//========================================
// loader testbench tasks
// value check, host download driver and
// the directed tests
//========================================

task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
	if (got !== expected) begin
		$display("FAIL %s got 0x%0h expected 0x%0h", name, got, expected);
		abort_run();
	end
endtask

//========================================
// host side driver
//========================================

task automatic start_download(input dl_index_t index);
	@(posedge clk_1x);
	ioctl_download <= 1'b1;
	ioctl_index    <= index;
	// kind registers on the next edge, one spare cycle before the first write
	repeat (2) @(posedge clk_1x);
endtask

task automatic end_download();
	@(posedge clk_1x);
	ioctl_download <= 1'b0;
endtask

// low half, then high half, then stall on ioctl_wait
task automatic send_word(input ram_addr_t addr, input ram_word_t data);
	int stall;
	@(posedge clk_1x);
	ioctl_addr <= addr;
	ioctl_dout <= data[15:0];
	ioctl_wr   <= 1'b1;
	@(posedge clk_1x);
	ioctl_addr <= addr | 27'd2;
	ioctl_dout <= data[31:16];
	@(posedge clk_1x);
	ioctl_wr <= 1'b0;
	@(negedge clk_1x);
	// word complete, host must now be held
	check_value("ioctl_wait", 64'(ioctl_wait), 64'd1);
	stall = 0;
	while (ioctl_wait) begin
		stall++;
		if (stall > 64) begin
			$display("ioctl_wait never dropped after a word was sent");
			abort_run();
		end
		@(negedge clk_1x);
	end
	if (outstanding != 0) begin
		$display("ioctl_wait dropped before the memory acknowledged the word");
		abort_run();
	end
endtask

// random words from consecutive word addresses
task automatic send_words(input int n, input ram_addr_t start, input ram_addr_t base);
	ram_addr_t addr;
	ram_word_t data;
	for (int i = 0; i < n; i++) begin
		addr = start + ram_addr_t'(4 * i);
		data = $random(seed);
		exp_addr_q.push_back(addr + base);
		exp_data_q.push_back(data);
		send_word(addr, data);
	end
endtask

// memory writes against the words sent, then clear all queues
task automatic compare_writes(input logic to_cd);
	int n;
	n = exp_addr_q.size();
	if (to_cd) begin
		check_value("cd write count", 64'(cd_addr_q.size()), 64'(n));
		check_value("main write count", 64'(main_addr_q.size()), 64'd0);
	end else begin
		check_value("main write count", 64'(main_addr_q.size()), 64'(n));
		check_value("cd write count", 64'(cd_addr_q.size()), 64'd0);
	end
	for (int i = 0; i < n; i++) begin
		if (to_cd) begin
			check_value("cd_addr", 64'(cd_addr_q[i]), 64'(exp_addr_q[i]));
			check_value("cd_data", 64'(cd_data_q[i]), 64'(exp_data_q[i]));
		end else begin
			check_value("main_addr", 64'(main_addr_q[i]), 64'(exp_addr_q[i]));
			check_value("main_data", 64'(main_data_q[i]), 64'(exp_data_q[i]));
		end
	end
	main_addr_q.delete();
	main_data_q.delete();
	cd_addr_q.delete();
	cd_data_q.delete();
	exp_addr_q.delete();
	exp_data_q.delete();
endtask

//========================================
// directed tests
//========================================

task automatic test_reset_values();
	@(negedge clk_1x);
	check_value("ioctl_wait", 64'(ioctl_wait), 64'd0);
	check_value("main_req", 64'(main_req), 64'd0);
	check_value("cd_req", 64'(cd_req), 64'd0);
	check_value("load_exe", 64'(load_exe), 64'd0);
	check_value("has_cd", 64'(has_cd), 64'd0);
	check_value("cd_from_card", 64'(cd_from_card), 64'd0);
	check_value("content_loaded", 64'(content_loaded), 64'd0);
	check_value("led_user", 64'(led_user), 64'd0);
endtask

task automatic test_bios_download();
	start_download(IDX_BIOS);
	send_words(bios_words, 27'h000, ram_addr_t'(bios_base));
	end_download();
	compare_writes(1'b0);
endtask

task automatic test_exe_download();
	start_download(IDX_EXE);
	@(negedge clk_1x);
	// system held in reset while the exe streams in
	check_value("core_reset", 64'(core_reset), 64'd1);
	// led lit for any active download
	check_value("led_user", 64'(led_user), 64'd1);
	send_words(exe_words, 27'h800, ram_addr_t'(exe_base));
	end_download();
	// start pulse two edges after the download falls
	for (int i = 0; i < 5; i++) begin
		@(negedge clk_1x);
		check_value("load_exe", 64'(load_exe), (i == 2) ? 64'd1 : 64'd0);
	end
	check_value("core_reset", 64'(core_reset), 64'd0);
	compare_writes(1'b0);
endtask

task automatic test_cd_download();
	// upper index bits pick a cd slot, low 6 bits decode the cd
	start_download(8'h42);
	send_words(cd_words, 27'h4000, ram_addr_t'(0));
	end_download();
	repeat (3) @(negedge clk_1x);
	// size is the high half address of the last word
	check_value("cd_size", 64'(cd_size), 64'(27'h4000 + 4 * (cd_words - 1) + 2));
	check_value("has_cd", 64'(has_cd), 64'd1);
	check_value("cd_from_card", 64'(cd_from_card), 64'd0);
	check_value("content_loaded", 64'(content_loaded), 64'd1);
	compare_writes(1'b1);
endtask

// random ack delays, one word in flight, every word written once
task automatic test_back_pressure();
	start_download(IDX_BIOS);
	send_words(bp_words, 27'h2000, ram_addr_t'(bios_base));
	end_download();
	compare_writes(1'b0);
endtask

task automatic test_image_mount();
	img_size_t mount_size;
	mount_size = 64'hffff_ffff_c123_4567;
	@(posedge clk_1x);
	img_mounted <= 1'b1;
	img_size    <= mount_size;
	@(negedge clk_1x);
	check_value("core_reset", 64'(core_reset), 64'd1);
	@(posedge clk_1x);
	img_mounted <= 1'b0;
	@(negedge clk_1x);
	check_value("cd_size", 64'(cd_size), 64'(mount_size[29:0]));
	check_value("cd_from_card", 64'(cd_from_card), 64'd1);
	check_value("has_cd", 64'(has_cd), 64'd1);
	check_value("core_reset", 64'(core_reset), 64'd0);
endtask

/* test/tb_psx_loader.sv */
//========================================
// psx loader testbench
// host download driver, memory ack model,
// watchdog and directed test sequence
//========================================
`timescale 1ns/10ps

module tb_psx_loader;
	import psx_load_pkg::*;

	localparam int unsigned bios_base = 2097152;
	localparam int unsigned exe_base  = 4194304;

	// words per directed test
	localparam int bios_words  = 8;
	localparam int exe_words   = 6;
	localparam int cd_words    = 10;
	localparam int bp_words    = 16;
	localparam int total_words = bios_words + exe_words + cd_words + bp_words;
	// 20 cycles per word plus setup margin
	localparam int timeout_cycles = total_words * 20 + 2000;

	logic       clk_1x;
	logic       reset;
	logic       ioctl_download;
	dl_index_t  ioctl_index;
	ram_addr_t  ioctl_addr;
	host_half_t ioctl_dout;
	logic       ioctl_wr;
	logic       ioctl_wait;
	logic       img_mounted;
	img_size_t  img_size;
	ram_addr_t  main_addr;
	ram_word_t  main_data;
	logic       main_req;
	logic       main_ack;
	ram_addr_t  cd_addr;
	ram_word_t  cd_data;
	logic       cd_req;
	logic       cd_ack;
	logic       load_exe;
	cd_size_t   cd_size;
	logic       has_cd;
	logic       cd_from_card;
	logic       content_loaded;
	logic       core_reset;
	logic       led_user;

	// writes seen by the memory model, and what the host sent
	ram_addr_t main_addr_q[$];
	ram_word_t main_data_q[$];
	ram_addr_t cd_addr_q[$];
	ram_word_t cd_data_q[$];
	ram_addr_t exp_addr_q[$];
	ram_word_t exp_data_q[$];

	integer    seed = 32'h073ca847;
	// words requested but not yet acknowledged
	int        outstanding;
	logic      ack_cd;
	logic [31:0] ack_delay;

	psx_loader_top #(
		.bios_base (bios_base),
		.exe_base  (exe_base)
	) i_psx_loader_top (.*);

	`include "loader_tasks.svh"

	initial begin
		clk_1x = 1'b0;
		forever #4 clk_1x = ~clk_1x;
	end

	//========================================
	// memory model
	//========================================

	// one ack per request after 0 to 7 idle cycles
	initial begin
		main_ack = 1'b0;
		cd_ack   = 1'b0;
		forever begin
			@(negedge clk_1x);
			if (main_req || cd_req) begin
				ack_cd = cd_req;
				if (ack_cd) begin
					cd_addr_q.push_back(cd_addr);
					cd_data_q.push_back(cd_data);
				end else begin
					main_addr_q.push_back(main_addr);
					main_data_q.push_back(main_data);
				end
				ack_delay = $random(seed);
				repeat (ack_delay[2:0]) @(posedge clk_1x);
				@(posedge clk_1x);
				if (ack_cd) begin
					cd_ack <= 1'b1;
				end else begin
					main_ack <= 1'b1;
				end
				@(posedge clk_1x);
				main_ack <= 1'b0;
				cd_ack   <= 1'b0;
			end
		end
	end

	// single word in flight, host held until the ack
	initial begin
		outstanding = 0;
		forever begin
			@(negedge clk_1x);
			if (main_req && cd_req) begin
				$display("both memory channels requested in the same cycle");
				abort_run();
			end
			if (main_req || cd_req) begin
				if (outstanding != 0) begin
					$display("second memory request while a word was still in flight");
					abort_run();
				end
				outstanding = 1;
			end
			if (outstanding != 0) begin
				check_value("ioctl_wait", 64'(ioctl_wait), 64'd1);
			end
			if (main_ack || cd_ack) begin
				outstanding = 0;
			end
		end
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk_1x);
		$display("watchdog expired before the test sequence finished");
		abort_run();
	end

	//========================================
	// test sequence
	//========================================

	initial begin
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		img_mounted    = 1'b0;
		img_size       = '0;
		repeat (16) @(posedge clk_1x);
		reset <= 1'b0;
		test_reset_values();
		test_bios_download();
		// cd first, so it is the first thing to set the loaded flag
		test_cd_download();
		test_exe_download();
		test_back_pressure();
		test_image_mount();
		$display("Result: PASSED");
		$finish;
	end

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

endmodule

/* tb.f */
+incdir+test
src/psx_load_pkg.sv
src/download_decoder.sv
src/download_writer.sv
src/psx_loader_top.sv
test/tb_psx_loader.sv

/* Makefile */
# Verilator build and run of the loader testbench

SIM  := obj_dir/Vtb_psx_loader
SRCS := $(shell grep -v '^+' tb.f) test/loader_tasks.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): tb.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_psx_loader -f tb.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
